/* vlog.f */
logic/axi_bus_pkg.sv
logic/mem_store_pkg.sv
logic/axi_mem_write.sv
logic/axi_mem_read.sv
logic/mem_port_arbiter.sv
logic/mem_store.sv
logic/axi_mem_top.sv
tb/tb_axi_mem.sv

/* run.sh */
#!/bin/sh
# Build the AXI memory testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_axi_mem -f vlog.f

./obj_dir/Vtb_axi_mem

/* tb/tb_axi_mem.sv */
// ================================================
// AXI4 slave memory testbench
// Directed bursts against a byte-level memory model
// with a side process checking the access monitor
// ================================================
`timescale 1ns/1ps

module tb_axi_mem
  import axi_bus_pkg::*;
  import mem_store_pkg::*;
;

  localparam int WAIT_LIMIT = 200;

  logic     clk;
  logic     rst_n;
  aw_chan_t aw_d;
  logic     aw_valid;
  w_chan_t  w_d;
  logic     w_valid;
  logic     b_ready;
  ar_chan_t ar_d;
  logic     ar_valid;
  logic     r_ready;
  axi_req_t req;
  axi_rsp_t rsp;
  mem_mon_t mon;

  integer   seed;
  logic [7:0] model_mem [MEM_WORDS*STRB_W];
  data_t    wdata_buf [16];
  strb_t    wstrb_buf [16];
  mem_mon_t exp_wr [$];
  mem_mon_t rd_mon [$];
  mem_mon_t exp_rec;
  mem_mon_t rd_rec;
  logic     w_hs_prev = 1'b0;
  logic     rd_mon_prev = 1'b0;
  logic     b_valid_prev = 1'b0;
  int       b_count = 0;

  assign req = '{aw: aw_d, aw_valid: aw_valid, w: w_d, w_valid: w_valid, b_ready: b_ready,
                 ar: ar_d, ar_valid: ar_valid, r_ready: r_ready};

  axi_mem_top axi_mem_top_inst (
    .clk_i     (clk),
    .rst_n_i   (rst_n),
    .axi_req_i (req),
    .axi_rsp_o (rsp),
    .mem_mon_o (mon)
  );

  always #20 clk = ~clk;

  task automatic abort_run(input string why);
    $display("=== FAIL ===");
    $fatal(1, "%s", why);
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      $display("** Error: %s is 0x%0h, expected 0x%0h", name, got, exp);
      abort_run("value mismatch");
    end
  endtask

  task automatic tick_timeout(inout int n, input string what);
    n++;
    if (n > WAIT_LIMIT) begin
      abort_run({"timed out waiting for ", what});
    end
  endtask

  function automatic int random_stall();
    return ($random(seed) & 7) + 1;
  endfunction

  // Word index wraps with the depth, so high address bits alias
  function automatic int byte_base(input addr_t addr);
    return int'((addr / STRB_W) % MEM_WORDS) * STRB_W;
  endfunction

  function automatic data_t model_word(input addr_t addr);
    data_t word;
    for (int b = 0; b < STRB_W; b++) begin
      word[b*8 +: 8] = model_mem[byte_base(addr) + b];
    end
    return word;
  endfunction

  function automatic void model_write(input addr_t addr, input data_t data, input strb_t strb);
    for (int b = 0; b < STRB_W; b++) begin
      if (strb[b]) begin
        model_mem[byte_base(addr) + b] = data[b*8 +: 8];
      end
    end
  endfunction

  task automatic write_burst(input id_t id, input addr_t addr, input int beats, input bit stall);
    addr_t base;
    addr_t beat_addr;
    int    n;
    int    b_before;
    base = addr & ~addr_t'(STRB_W - 1);
    b_before = b_count;
    @(negedge clk);
    aw_d = '{id: id, addr: addr, len: len_t'(beats - 1)};
    aw_valid = 1'b1;
    n = 0;
    do begin
      @(posedge clk);
      tick_timeout(n, "AW handshake");
    end while (!rsp.aw_ready);
    @(negedge clk);
    aw_valid = 1'b0;
    for (int i = 0; i < beats; i++) begin
      beat_addr = base + addr_t'(i * STRB_W);
      w_d = '{data: wdata_buf[i], strb: wstrb_buf[i], last: (i == beats - 1)};
      w_valid = 1'b1;
      exp_wr.push_back('{valid: 1'b1, write: 1'b1, addr: beat_addr, data: wdata_buf[i],
                         id: id, beat: len_t'(i), last: (i == beats - 1)});
      n = 0;
      do begin
        @(posedge clk);
        tick_timeout(n, "W handshake");
      end while (!rsp.w_ready);
      model_write(beat_addr, wdata_buf[i], wstrb_buf[i]);
      @(negedge clk);
    end
    w_valid = 1'b0;
    n = 0;
    do begin
      @(posedge clk);
      tick_timeout(n, "B response");
    end while (!rsp.b_valid);
    @(negedge clk);
    if (stall) begin
      repeat (random_stall()) @(negedge clk);
    end
    check_value("b_valid", rsp.b_valid, 1'b1);
    check_value("b.id", rsp.b.id, id);
    check_value("b.resp", rsp.b.resp, RESP_OKAY);
    b_ready = 1'b1;
    @(negedge clk);
    b_ready = 1'b0;
    // One B per burst
    check_value("b_valid after B", rsp.b_valid, 1'b0);
    check_value("B count", b_count, b_before + 1);
  endtask

  task automatic read_burst(input id_t id, input addr_t addr, input int beats, input bit stall);
    addr_t   base;
    r_chan_t held;
    int      n;
    base = addr & ~addr_t'(STRB_W - 1);
    @(negedge clk);
    ar_d = '{id: id, addr: addr, len: len_t'(beats - 1)};
    ar_valid = 1'b1;
    n = 0;
    do begin
      @(posedge clk);
      tick_timeout(n, "AR handshake");
    end while (!rsp.ar_ready);
    @(negedge clk);
    ar_valid = 1'b0;
    for (int i = 0; i < beats; i++) begin
      n = 0;
      do begin
        @(posedge clk);
        tick_timeout(n, "R beat");
      end while (!rsp.r_valid);
      @(negedge clk);
      held = rsp.r;
      check_value("r.data", held.data, model_word(base + addr_t'(i * STRB_W)));
      check_value("r.id", held.id, id);
      check_value("r.resp", held.resp, RESP_OKAY);
      check_value("r.last", held.last, (i == beats - 1));
      if (stall) begin
        repeat (random_stall()) @(negedge clk);
      end
      // R must stay put while r_ready is low
      check_value("r_valid", rsp.r_valid, 1'b1);
      check_value("r under stall", rsp.r, held);
      r_ready = 1'b1;
      @(negedge clk);
      r_ready = 1'b0;
    end
  endtask

  task automatic single_beat_write_read();
    wdata_buf[0] = 32'hA5A5_1234;
    wstrb_buf[0] = 4'hF;
    write_burst(4'h3, 32'h40, 1, 1'b0);
    read_burst(4'h5, 32'h40, 1, 1'b0);
  endtask

  task automatic strobed_burst_readback();
    for (int i = 0; i < 4; i++) begin
      wdata_buf[i] = 32'h1111_1111 * (i + 1);
      wstrb_buf[i] = 4'hF;
    end
    write_burst(4'h1, 32'h100, 4, 1'b0);
    for (int i = 0; i < 4; i++) begin
      wdata_buf[i] = 32'hDEAD_BE00 | i;
    end
    wstrb_buf[0] = 4'b0001;
    wstrb_buf[1] = 4'b0110;
    wstrb_buf[2] = 4'b1000;
    wstrb_buf[3] = 4'b1010;
    // Unaligned start address aligns down to 0x100
    write_burst(4'h2, 32'h102, 4, 1'b0);
    read_burst(4'h7, 32'h100, 4, 1'b0);
  endtask

  task automatic backpressured_bursts();
    for (int i = 0; i < 5; i++) begin
      wdata_buf[i] = $random(seed);
      wstrb_buf[i] = 4'hF;
    end
    write_burst(4'h9, 32'h300, 5, 1'b1);
    read_burst(4'hA, 32'h300, 5, 1'b1);
  endtask

  task automatic concurrent_bursts();
    for (int i = 0; i < 4; i++) begin
      wdata_buf[i] = 32'hC0DE_0000 + i;
      wstrb_buf[i] = 4'hF;
    end
    fork
      write_burst(4'h4, 32'h200, 4, 1'b0);
      read_burst(4'h6, 32'h300, 4, 1'b0);
    join
    read_burst(4'h8, 32'h200, 4, 1'b0);
  endtask

  task automatic address_aliasing();
    wdata_buf[0] = 32'h0BAD_F00D;
    wstrb_buf[0] = 4'hF;
    write_burst(4'hC, 32'h80, 1, 1'b0);
    // 1024 bytes above lands on the same word
    wdata_buf[0] = 32'h600D_CAFE;
    write_burst(4'hD, 32'h80 + 32'd1024, 1, 1'b0);
    read_burst(4'hB, 32'h80, 1, 1'b0);
  endtask

  // Monitor records against W and R handshakes
  always @(posedge clk) begin
    if (rst_n) begin
      check_value("mon write record", mon.valid && mon.write, w_hs_prev);
      if (rd_mon_prev) begin
        check_value("r_valid after read record", rsp.r_valid, 1'b1);
      end
      if (mon.valid && mon.write) begin
        if (exp_wr.size() == 0) begin
          abort_run("write monitor record without a W beat");
        end else begin
          exp_rec = exp_wr.pop_front();
          check_value("mon.addr", mon.addr, exp_rec.addr);
          check_value("mon.data", mon.data, exp_rec.data);
          check_value("mon.id", mon.id, exp_rec.id);
          check_value("mon.beat", mon.beat, exp_rec.beat);
          check_value("mon.last", mon.last, exp_rec.last);
        end
      end
      if (rsp.r_valid && r_ready) begin
        if (rd_mon.size() == 0) begin
          abort_run("R beat without a read monitor record");
        end else begin
          rd_rec = rd_mon.pop_front();
          check_value("r.data vs mon", rsp.r.data, rd_rec.data);
          check_value("r.id vs mon", rsp.r.id, rd_rec.id);
        end
      end
      if (mon.valid && !mon.write) begin
        check_value("r_valid at read record", rsp.r_valid, 1'b0);
        rd_mon.push_back(mon);
      end
      // Each rise of b_valid is one B response
      if (rsp.b_valid && !b_valid_prev) begin
        b_count++;
      end
      w_hs_prev = w_valid && rsp.w_ready;
      rd_mon_prev = mon.valid && !mon.write;
      b_valid_prev = rsp.b_valid;
    end
  end

  initial begin
    seed = 4;
    clk = 1'b0;
    rst_n = 1'b0;
    aw_d = '0;
    aw_valid = 1'b0;
    w_d = '0;
    w_valid = 1'b0;
    b_ready = 1'b0;
    ar_d = '0;
    ar_valid = 1'b0;
    r_ready = 1'b0;
    repeat (2) @(negedge clk);
    rst_n = 1'b1;
    check_value("aw_ready in reset", rsp.aw_ready, 1'b0);
    check_value("mon.valid in reset", mon.valid, 1'b0);
    @(negedge clk);
    check_value("aw_ready", rsp.aw_ready, 1'b1);
    check_value("ar_ready", rsp.ar_ready, 1'b1);
    single_beat_write_read();
    strobed_burst_readback();
    backpressured_bursts();
    concurrent_bursts();
    address_aliasing();
    repeat (3) @(negedge clk);
    check_value("pending write records", exp_wr.size(), 0);
    check_value("pending read records", rd_mon.size(), 0);
    $display("=== PASS ===");
    $finish;
  end

endmodule

/* logic/axi_mem_top.sv */
// ================================================
// AXI4 slave memory
// Write and read engines sharing one storage array
// through a round-robin port arbiter
// ================================================
`timescale 1ns/1ps

module axi_mem_top
  import axi_bus_pkg::*;
  import mem_store_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  axi_req_t axi_req_i,
  output axi_rsp_t axi_rsp_o,
  output mem_mon_t mem_mon_o
);

  logic     wr_req;
  logic     wr_gnt;
  mem_req_t wr_mem;
  logic     rd_req;
  logic     rd_gnt;
  mem_req_t rd_mem;
  logic     port_valid;
  mem_req_t port;
  data_t    rd_data;

  axi_mem_write axi_mem_write_inst (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .aw_i       (axi_req_i.aw),
    .aw_valid_i (axi_req_i.aw_valid),
    .aw_ready_o (axi_rsp_o.aw_ready),
    .w_i        (axi_req_i.w),
    .w_valid_i  (axi_req_i.w_valid),
    .w_ready_o  (axi_rsp_o.w_ready),
    .b_o        (axi_rsp_o.b),
    .b_valid_o  (axi_rsp_o.b_valid),
    .b_ready_i  (axi_req_i.b_ready),
    .wr_req_o   (wr_req),
    .wr_gnt_i   (wr_gnt),
    .wr_o       (wr_mem)
  );

  axi_mem_read axi_mem_read_inst (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .ar_i       (axi_req_i.ar),
    .ar_valid_i (axi_req_i.ar_valid),
    .ar_ready_o (axi_rsp_o.ar_ready),
    .r_o        (axi_rsp_o.r),
    .r_valid_o  (axi_rsp_o.r_valid),
    .r_ready_i  (axi_req_i.r_ready),
    .rd_req_o   (rd_req),
    .rd_gnt_i   (rd_gnt),
    .rd_o       (rd_mem),
    .rd_data_i  (rd_data)
  );

  mem_port_arbiter mem_port_arbiter_inst (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .wr_req_i     (wr_req),
    .wr_i         (wr_mem),
    .rd_req_i     (rd_req),
    .rd_i         (rd_mem),
    .wr_gnt_o     (wr_gnt),
    .rd_gnt_o     (rd_gnt),
    .port_valid_o (port_valid),
    .port_o       (port)
  );

  mem_store mem_store_inst (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .port_valid_i (port_valid),
    .port_i       (port),
    .rd_data_o    (rd_data),
    .mem_mon_o    (mem_mon_o)
  );

endmodule

/* logic/mem_store.sv */
// ================================================
// Word storage with access monitor
// Byte-strobed writes, registered reads and a record of
// every access one cycle after it happens
// ================================================
`timescale 1ns/1ps

module mem_store
  import axi_bus_pkg::*;
  import mem_store_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     port_valid_i,
  input  mem_req_t port_i,
  output data_t    rd_data_o,
  output mem_mon_t mem_mon_o
);

  data_t     mem_q [MEM_WORDS];
  data_t     rd_data_q;
  mem_mon_t  mon_q;
  word_idx_t idx;

  // Upper address bits drop out, so the index wraps with the depth
  assign idx = port_i.addr[BYTE_OFF_W +: IDX_W];

  always_ff @(posedge clk_i) begin
    if (port_valid_i && port_i.write) begin
      for (int b = 0; b < STRB_W; b++) begin
        if (port_i.strb[b]) begin
          mem_q[idx][b*8 +: 8] <= port_i.wdata[b*8 +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (port_valid_i && !port_i.write) begin
      rd_data_q <= mem_q[idx];
    end
  end

  // Write records carry the W data, read records the stored word
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      mon_q.valid <= 1'b0;
    end else begin
      mon_q.valid <= port_valid_i;
      mon_q.write <= port_i.write;
      mon_q.addr  <= port_i.addr;
      mon_q.data  <= port_i.write ? port_i.wdata : mem_q[idx];
      mon_q.id    <= port_i.id;
      mon_q.beat  <= port_i.beat;
      mon_q.last  <= port_i.last;
    end
  end

  assign rd_data_o = rd_data_q;
  assign mem_mon_o = mon_q;

endmodule

/* logic/mem_port_arbiter.sv */
// ================================================
// Memory port arbiter
// Round-robin grant of the single storage port to the
// write or the read engine
// ================================================
`timescale 1ns/1ps

module mem_port_arbiter
  import mem_store_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     wr_req_i,
  input  mem_req_t wr_i,
  input  logic     rd_req_i,
  input  mem_req_t rd_i,
  output logic     wr_gnt_o,
  output logic     rd_gnt_o,
  output logic     port_valid_o,
  output mem_req_t port_o
);

  // High when the write engine won the last contested or uncontested grant
  logic last_wr_q;

  assign wr_gnt_o = wr_req_i && (!rd_req_i || !last_wr_q);
  assign rd_gnt_o = rd_req_i && (!wr_req_i || last_wr_q);

  assign port_valid_o = wr_gnt_o || rd_gnt_o;
  assign port_o       = wr_gnt_o ? wr_i : rd_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      last_wr_q <= 1'b0;
    end else if (wr_gnt_o) begin
      last_wr_q <= 1'b1;
    end else if (rd_gnt_o) begin
      last_wr_q <= 1'b0;
    end
  end

endmodule

/* logic/axi_mem_read.sv */
// ================================================
// AXI read engine
// Takes one AR burst at a time and fetches one word per
// beat into a held R register
// ================================================
`timescale 1ns/1ps

module axi_mem_read
  import axi_bus_pkg::*;
  import mem_store_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  ar_chan_t ar_i,
  input  logic     ar_valid_i,
  output logic     ar_ready_o,
  output r_chan_t  r_o,
  output logic     r_valid_o,
  input  logic     r_ready_i,
  output logic     rd_req_o,
  input  logic     rd_gnt_i,
  output mem_req_t rd_o,
  input  data_t    rd_data_i
);

  typedef enum logic [1:0] {R_IDLE, R_REQ, R_WAIT, R_SEND} rd_state_e;

  rd_state_e state_q;
  rd_state_e state_d;
  ar_chan_t  ar_q;
  r_chan_t   r_q;
  len_t      beat_q;
  logic      ar_ready_q;
  logic      last_beat;
  addr_t     beat_addr;

  assign last_beat = (beat_q == ar_q.len);
  assign beat_addr = ar_q.addr + (addr_t'(beat_q) << BYTE_OFF_W);

  always_comb begin
    state_d = state_q;
    case (state_q)
      R_IDLE: begin
        if (ar_valid_i && ar_ready_q) begin
          state_d = R_REQ;
        end
      end
      R_REQ: begin
        if (rd_gnt_i) begin
          state_d = R_WAIT;
        end
      end
      // Read data arrives one cycle after the grant
      R_WAIT: state_d = R_SEND;
      R_SEND: begin
        if (r_ready_i) begin
          state_d = last_beat ? R_IDLE : R_REQ;
        end
      end
      default: state_d = R_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q    <= R_IDLE;
      ar_ready_q <= 1'b0;
      beat_q     <= '0;
    end else begin
      state_q    <= state_d;
      ar_ready_q <= (state_d == R_IDLE);
      if (state_q == R_IDLE) begin
        beat_q <= '0;
      end else if (state_q == R_SEND && r_ready_i) begin
        beat_q <= beat_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (ar_valid_i && ar_ready_q) begin
      ar_q <= '{id:   ar_i.id,
                addr: {ar_i.addr[ADDR_W-1:BYTE_OFF_W], {BYTE_OFF_W{1'b0}}},
                len:  ar_i.len};
    end
  end

  // R beat stays put until r_ready
  always_ff @(posedge clk_i) begin
    if (state_q == R_WAIT) begin
      r_q <= '{data: rd_data_i, id: ar_q.id, resp: RESP_OKAY, last: last_beat};
    end
  end

  assign ar_ready_o = ar_ready_q;
  assign rd_req_o   = (state_q == R_REQ);
  assign r_valid_o  = (state_q == R_SEND);
  assign r_o        = r_q;

  assign rd_o = '{write: 1'b0,
                  addr:  beat_addr,
                  wdata: '0,
                  strb:  '0,
                  id:    ar_q.id,
                  beat:  beat_q,
                  last:  last_beat};

endmodule

/* logic/axi_mem_write.sv */
// ================================================
// AXI write engine
// Takes one AW burst at a time, turns each W beat into
// a strobed memory write and returns a B response
// ================================================
`timescale 1ns/1ps

module axi_mem_write
  import axi_bus_pkg::*;
  import mem_store_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  aw_chan_t aw_i,
  input  logic     aw_valid_i,
  output logic     aw_ready_o,
  input  w_chan_t  w_i,
  input  logic     w_valid_i,
  output logic     w_ready_o,
  output b_chan_t  b_o,
  output logic     b_valid_o,
  input  logic     b_ready_i,
  output logic     wr_req_o,
  input  logic     wr_gnt_i,
  output mem_req_t wr_o
);

  typedef enum logic [1:0] {W_IDLE, W_DATA, W_RESP} wr_state_e;

  wr_state_e state_q;
  wr_state_e state_d;
  aw_chan_t  aw_q;
  len_t      beat_q;
  logic      aw_ready_q;
  logic      last_beat;
  addr_t     beat_addr;

  assign last_beat = (beat_q == aw_q.len);
  // Aligned base plus beat times the word size
  assign beat_addr = aw_q.addr + (addr_t'(beat_q) << BYTE_OFF_W);

  always_comb begin
    state_d = state_q;
    case (state_q)
      W_IDLE: begin
        if (aw_valid_i && aw_ready_q) begin
          state_d = W_DATA;
        end
      end
      W_DATA: begin
        if (wr_gnt_i && last_beat) begin
          state_d = W_RESP;
        end
      end
      W_RESP: begin
        if (b_ready_i) begin
          state_d = W_IDLE;
        end
      end
      default: state_d = W_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q    <= W_IDLE;
      aw_ready_q <= 1'b0;
      beat_q     <= '0;
    end else begin
      state_q    <= state_d;
      aw_ready_q <= (state_d == W_IDLE);
      if (state_q == W_IDLE) begin
        beat_q <= '0;
      end else if (wr_gnt_i) begin
        beat_q <= beat_q + 1'b1;
      end
    end
  end

  // Burst descriptor, address aligned down to a word
  always_ff @(posedge clk_i) begin
    if (aw_valid_i && aw_ready_q) begin
      aw_q <= '{id:   aw_i.id,
                addr: {aw_i.addr[ADDR_W-1:BYTE_OFF_W], {BYTE_OFF_W{1'b0}}},
                len:  aw_i.len};
    end
  end

  assign aw_ready_o = aw_ready_q;
  // A W beat is taken exactly when the memory port is granted
  assign w_ready_o  = wr_gnt_i;
  assign wr_req_o   = (state_q == W_DATA) && w_valid_i;
  assign b_valid_o  = (state_q == W_RESP);
  assign b_o        = '{id: aw_q.id, resp: RESP_OKAY};

  assign wr_o = '{write: 1'b1,
                  addr:  beat_addr,
                  wdata: w_i.data,
                  strb:  w_i.strb,
                  id:    aw_q.id,
                  beat:  beat_q,
                  last:  last_beat};

endmodule

/* logic/mem_store_pkg.sv */
// ================================================
// Storage definitions
// Depth, word index and the memory port and monitor
// records shared by the engines and the array
// ================================================
package mem_store_pkg;

  import axi_bus_pkg::*;

  localparam int unsigned MEM_WORDS  = 256;
  localparam int unsigned IDX_W      = $clog2(MEM_WORDS);
  // Byte offset bits below the word index
  localparam int unsigned BYTE_OFF_W = $clog2(STRB_W);

  typedef logic [IDX_W-1:0] word_idx_t;

  // One access on the shared memory port
  typedef struct packed {
    logic  write;
    addr_t addr;
    data_t wdata;
    strb_t strb;
    id_t   id;
    len_t  beat;
    logic  last;
  } mem_req_t;

  // Monitor record, valid the cycle after the access
  typedef struct packed {
    logic  valid;
    logic  write;
    addr_t addr;
    data_t data;
    id_t   id;
    len_t  beat;
    logic  last;
  } mem_mon_t;

endpackage

/* logic/axi_bus_pkg.sv */
// ================================================
// AXI4 bus definitions
// Field widths, channel structs and the request and
// response bundles of the slave port
// ================================================
package axi_bus_pkg;

  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;
  localparam int unsigned ID_W   = 4;
  localparam int unsigned STRB_W = DATA_W / 8;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [ID_W-1:0]   id_t;
  typedef logic [STRB_W-1:0] strb_t;
  // Beat count minus one
  typedef logic [7:0]        len_t;

  // Only OKAY is ever returned
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_EXOKAY = 2'b01,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } resp_e;

  typedef struct packed {
    id_t   id;
    addr_t addr;
    len_t  len;
  } aw_chan_t;

  typedef struct packed {
    id_t   id;
    addr_t addr;
    len_t  len;
  } ar_chan_t;

  typedef struct packed {
    data_t data;
    strb_t strb;
    logic  last;
  } w_chan_t;

  typedef struct packed {
    id_t   id;
    resp_e resp;
  } b_chan_t;

  typedef struct packed {
    data_t data;
    id_t   id;
    resp_e resp;
    logic  last;
  } r_chan_t;

  typedef struct packed {
    aw_chan_t aw;
    logic     aw_valid;
    w_chan_t  w;
    logic     w_valid;
    logic     b_ready;
    ar_chan_t ar;
    logic     ar_valid;
    logic     r_ready;
  } axi_req_t;

  typedef struct packed {
    logic    aw_ready;
    logic    w_ready;
    b_chan_t b;
    logic    b_valid;
    logic    ar_ready;
    r_chan_t r;
    logic    r_valid;
  } axi_rsp_t;

endpackage
